// ==== all.f ====
hw/cart_pkg.sv
hw/snes_bus_sync.sv
hw/address.sv
hw/feature_regs.sv
hw/sram_req.sv
hw/cart_top.sv
tests/cart_checker.sv
tests/tb_cart.sv

// ==== hw/address.sv ====
`timescale 1ns/100ps
`default_nettype none

module address import cart_pkg::*; (
  input  wire logic [feat_w-1:0]      featurebits,   // Peripheral enables
  input  wire logic [snes_addr_w-1:0] snes_addr,     // Synchronized A-bus
  input  wire logic [pa_w-1:0]        snes_pa,       // Synchronized B-bus
  input  wire logic                   snes_romsel,
  input  wire logic [snes_addr_w-1:0] saveram_mask,
  input  wire logic [snes_addr_w-1:0] rom_mask,
  output logic      [snes_addr_w-1:0] rom_addr,      // SRAM address
  output logic                        rom_hit,
  output logic                        is_saveram,
  output logic                        is_rom,
  output logic                        is_writable,
  output logic                        msu_enable,
  output logic                        r213f_enable,
  output logic                        r2100_hit,
  output logic                        snescmd_enable,
  output logic                        nmicmd_enable,
  output logic                        return_vector_enable,
  output logic                        branch1_enable,
  output logic                        branch2_enable,
  output logic                        branch3_enable,
  output logic                        gsu_enable
);

  logic                   hi_bank;     // Banks 40-7F/C0-FF
  logic [snes_addr_w-1:0] sav_offset;
  logic [snes_addr_w-1:0] rom_fold;

  assign hi_bank = snes_addr[22];

  //////////////////////////////////////////////////
  // Region decode
  //////////////////////////////////////////////////
  // LoROM half banks, or whole HiROM banks under ROMSEL
  assign is_rom = (~hi_bank & snes_addr[15]) | (hi_bank & ~snes_romsel);

  assign is_saveram = saveram_mask[0]
                    & ((&snes_addr[22:21] & ~snes_romsel)                // 60-7F/E0-FF
                     | (~hi_bank & ~snes_addr[15] & &snes_addr[14:13])); // x:6000-7FFF

  assign is_writable = is_saveram;  // ROM is never written
  assign rom_hit     = is_rom | is_writable;

  //////////////////////////////////////////////////
  // Address translation
  //////////////////////////////////////////////////
  // 128K window up high, 8K mirror in the low banks
  assign sav_offset = hi_bank ? {7'd0, snes_addr[16:0]} : {11'd0, snes_addr[12:0]};

  // HiROM fold up high, LoROM drops A15 down low
  assign rom_fold = hi_bank ? {2'b00, snes_addr[21:0]}
                            : {3'b000, snes_addr[21:16], snes_addr[14:0]};

  assign rom_addr = is_saveram ? (sram_base + (sav_offset & saveram_mask))
                               : (rom_fold & rom_mask);

  //////////////////////////////////////////////////
  // Peripheral enables
  //////////////////////////////////////////////////
  assign msu_enable   = featurebits[feat_msu1] & ~hi_bank
                      & (snes_addr[15:3] == 13'h0400);  // 2000-2007
  assign r213f_enable = featurebits[feat_213f] & (snes_pa == 8'h3F);
  assign r2100_hit    = (snes_pa == 8'h00);             // Always decoded

  // 2A00-2BFF command area
  assign snescmd_enable = ~hi_bank & (snes_addr[15:9] == 7'b0010101);

  assign nmicmd_enable        = (snes_addr == nmicmd_addr);
  assign return_vector_enable = (snes_addr == return_vector_addr);
  assign branch1_enable       = (snes_addr == branch1_addr);
  assign branch2_enable       = (snes_addr == branch2_addr);
  assign branch3_enable       = (snes_addr == branch3_addr);

  // 3000-32FF, 3300-33FF excluded
  assign gsu_enable = ~hi_bank & (snes_addr[15:10] == 6'b001100)
                    & (snes_addr[9:8] != 2'b11);

endmodule

`default_nettype wire

// ==== hw/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////
  localparam int snes_addr_w = 24;  // Console A-bus
  localparam int pa_w        = 8;   // B-bus peripheral address
  localparam int feat_w      = 16;  // Feature enable vector

  // Feature bit positions within featurebits
  localparam int feat_msu1 = 3;  // MSU audio regs
  localparam int feat_213f = 4;  // 213F override
  localparam int feat_2100 = 6;  // Reserved, 2100 hit is ungated

  //////////////////////////////////////////////////
  // Config register map, byte wide
  //////////////////////////////////////////////////
  localparam logic [3:0] cfg_feat_lo    = 4'd0;
  localparam logic [3:0] cfg_feat_hi    = 4'd1;
  localparam logic [3:0] cfg_sav_mask_0 = 4'd2;  // Low byte
  localparam logic [3:0] cfg_sav_mask_1 = 4'd3;
  localparam logic [3:0] cfg_sav_mask_2 = 4'd4;  // High byte
  localparam logic [3:0] cfg_rom_mask_0 = 4'd5;
  localparam logic [3:0] cfg_rom_mask_1 = 4'd6;
  localparam logic [3:0] cfg_rom_mask_2 = 4'd7;

  // Reset values
  localparam logic [feat_w-1:0]      rst_featurebits  = '0;         // All off
  localparam logic [snes_addr_w-1:0] rst_saveram_mask = '0;         // No save RAM
  localparam logic [snes_addr_w-1:0] rst_rom_mask     = 24'hFFFFFF; // Full 16 MB

  //////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////
  // Save RAM lives at the top of SRAM
  localparam logic [snes_addr_w-1:0] sram_base = 24'hE00000;

  // Patch and command hooks, bank 00
  localparam logic [snes_addr_w-1:0] nmicmd_addr        = 24'h002BF2;
  localparam logic [snes_addr_w-1:0] return_vector_addr = 24'h002A6C;
  localparam logic [snes_addr_w-1:0] branch1_addr       = 24'h002A1F;
  localparam logic [snes_addr_w-1:0] branch2_addr       = 24'h002A59;
  localparam logic [snes_addr_w-1:0] branch3_addr       = 24'h002A5E;

endpackage

`default_nettype wire

// ==== hw/cart_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cart_top import cart_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // Console bus, asynchronous
  input  wire logic [snes_addr_w-1:0] snes_addr,
  input  wire logic [pa_w-1:0]        snes_pa,
  input  wire logic                   snes_romsel,
  input  wire logic                   snes_rd_n,
  input  wire logic                   snes_wr_n,
  input  wire logic [7:0]             snes_data_in,
  // MCU config port
  input  wire logic                   cfg_we,
  input  wire logic [3:0]             cfg_addr,
  input  wire logic [7:0]             cfg_data,
  // Decode results
  output logic      [snes_addr_w-1:0] rom_addr,
  output logic                        rom_hit,
  output logic                        is_saveram,
  output logic                        is_rom,
  output logic                        is_writable,
  output logic                        msu_enable,
  output logic                        r213f_enable,
  output logic                        r2100_hit,
  output logic                        snescmd_enable,
  output logic                        nmicmd_enable,
  output logic                        return_vector_enable,
  output logic                        branch1_enable,
  output logic                        branch2_enable,
  output logic                        branch3_enable,
  output logic                        gsu_enable,
  // SRAM requests
  output logic      [snes_addr_w-1:0] mem_addr,
  output logic                        mem_rd,
  output logic                        mem_wr,
  output logic      [7:0]             mem_wdata
);

  logic [snes_addr_w-1:0] sync_addr;
  logic [pa_w-1:0]        sync_pa;
  logic                   sync_romsel;
  logic [7:0]             sync_data;
  logic                   rd_start;
  logic                   wr_end;
  logic [feat_w-1:0]      featurebits;
  logic [snes_addr_w-1:0] saveram_mask;
  logic [snes_addr_w-1:0] rom_mask;

  //////////////////////////////////////////////////
  // Bus capture
  //////////////////////////////////////////////////
  snes_bus_sync i_snes_bus_sync (
    .clk, .rst_n, .snes_addr, .snes_pa, .snes_romsel, .snes_rd_n, .snes_wr_n,
    .snes_data_in, .sync_addr, .sync_pa, .sync_romsel, .sync_data, .rd_start, .wr_end
  );

  feature_regs i_feature_regs (
    .clk, .rst_n, .cfg_we, .cfg_addr, .cfg_data, .featurebits, .saveram_mask, .rom_mask
  );

  // Decoder sees the synchronized bus only
  address i_address (
    .featurebits, .snes_addr(sync_addr), .snes_pa(sync_pa), .snes_romsel(sync_romsel),
    .saveram_mask, .rom_mask, .rom_addr, .rom_hit, .is_saveram, .is_rom, .is_writable,
    .msu_enable, .r213f_enable, .r2100_hit, .snescmd_enable, .nmicmd_enable,
    .return_vector_enable, .branch1_enable, .branch2_enable, .branch3_enable, .gsu_enable
  );

  sram_req i_sram_req (
    .clk, .rst_n, .rd_start, .wr_end, .rom_hit, .is_writable, .rom_addr, .sync_data,
    .mem_addr, .mem_rd, .mem_wr, .mem_wdata
  );

endmodule

`default_nettype wire

// ==== hw/feature_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module feature_regs import cart_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   cfg_we,        // One-cycle pulse
  input  wire logic [3:0]             cfg_addr,
  input  wire logic [7:0]             cfg_data,
  output logic      [feat_w-1:0]      featurebits,
  output logic      [snes_addr_w-1:0] saveram_mask,
  output logic      [snes_addr_w-1:0] rom_mask
);

  //////////////////////////////////////////////////
  // Byte-wide register file
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      featurebits  <= rst_featurebits;
      saveram_mask <= rst_saveram_mask;
      rom_mask     <= rst_rom_mask;
    end else if (cfg_we) begin
      case (cfg_addr)
        cfg_feat_lo:    featurebits[7:0]    <= cfg_data;
        cfg_feat_hi:    featurebits[15:8]   <= cfg_data;
        cfg_sav_mask_0: saveram_mask[7:0]   <= cfg_data;  // Bit 0 enables save RAM
        cfg_sav_mask_1: saveram_mask[15:8]  <= cfg_data;
        cfg_sav_mask_2: saveram_mask[23:16] <= cfg_data;
        cfg_rom_mask_0: rom_mask[7:0]       <= cfg_data;
        cfg_rom_mask_1: rom_mask[15:8]      <= cfg_data;
        cfg_rom_mask_2: rom_mask[23:16]     <= cfg_data;
        default: ;                                        // 8-15 unmapped
      endcase
    end
  end

  // MCU link must never present a floating address
  a_cfg_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n) cfg_we |-> !$isunknown(cfg_addr)
  );

endmodule

`default_nettype wire

// ==== hw/snes_bus_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module snes_bus_sync import cart_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic [snes_addr_w-1:0] snes_addr,     // Async from console
  input  wire logic [pa_w-1:0]        snes_pa,
  input  wire logic                   snes_romsel,   // Active low
  input  wire logic                   snes_rd_n,
  input  wire logic                   snes_wr_n,
  input  wire logic [7:0]             snes_data_in,
  output logic      [snes_addr_w-1:0] sync_addr,
  output logic      [pa_w-1:0]        sync_pa,
  output logic                        sync_romsel,
  output logic      [7:0]             sync_data,
  output logic                        rd_start,      // Read strobe fell
  output logic                        wr_end         // Write strobe rose
);

  logic [snes_addr_w-1:0] addr_s1;
  logic [pa_w-1:0]        pa_s1;
  logic [7:0]             data_s1;
  logic [1:0]             romsel_sr;  // Two sync stages
  logic [2:0]             rd_sr;      // [2] is the edge-detect history
  logic [2:0]             wr_sr;

  //////////////////////////////////////////////////
  // Payload stages, no reset needed
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    addr_s1   <= snes_addr;
    pa_s1     <= snes_pa;
    data_s1   <= snes_data_in;
    sync_addr <= addr_s1;  // Stage 2
    sync_pa   <= pa_s1;
    sync_data <= data_s1;
  end

  // Strobes and ROMSEL come up inactive
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      romsel_sr <= 2'b11;
      rd_sr     <= 3'b111;
      wr_sr     <= 3'b111;
    end else begin
      romsel_sr <= {romsel_sr[0], snes_romsel};
      rd_sr     <= {rd_sr[1:0], snes_rd_n};
      wr_sr     <= {wr_sr[1:0], snes_wr_n};
    end
  end

  assign sync_romsel = romsel_sr[1];

  // High-to-low on read, low-to-high on write
  assign rd_start = rd_sr[2] & ~rd_sr[1];
  assign wr_end   = ~wr_sr[2] & wr_sr[1];

  // A console cycle is either a read or a write
  a_no_rd_wr_overlap: assert property (
    @(posedge clk) disable iff (!rst_n) !(rd_start && wr_end)
  );

endmodule

`default_nettype wire

// ==== hw/sram_req.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_req import cart_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   rd_start,    // From synchronizer
  input  wire logic                   wr_end,
  input  wire logic                   rom_hit,     // From decoder
  input  wire logic                   is_writable,
  input  wire logic [snes_addr_w-1:0] rom_addr,
  input  wire logic [7:0]             sync_data,
  output logic      [snes_addr_w-1:0] mem_addr,    // Held until next request
  output logic                        mem_rd,      // Single-cycle strobe
  output logic                        mem_wr,
  output logic      [7:0]             mem_wdata
);

  logic rd_req;
  logic wr_req;

  // Only mapped space generates traffic
  assign rd_req = rd_start & rom_hit;
  assign wr_req = wr_end & is_writable;

  //////////////////////////////////////////////////
  // Request strobes
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rd <= 1'b0;
      mem_wr <= 1'b0;
    end else begin
      mem_rd <= rd_req;
      mem_wr <= wr_req;
    end
  end

  // Address and data latch
  always_ff @(posedge clk) begin
    if (rd_req || wr_req) begin
      mem_addr <= rom_addr;   // Last access wins
    end
    if (wr_req) begin
      mem_wdata <= sync_data;
    end
  end

  // No arbitration downstream
  a_rd_wr_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the cartridge decode testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_cart -f all.f -o sim_cart \
  && ./obj_dir/sim_cart | tee sim.log \
  && grep -q "^TEST PASSED$" sim.log \
  && echo "run.sh: pass message found in sim.log" \
  || { echo "run.sh: no pass message in sim.log"; exit 1; }

// ==== tests/cart_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cart_checker import cart_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // Stimulus as seen at the DUT pins
  input  wire logic [snes_addr_w-1:0] snes_addr,
  input  wire logic [pa_w-1:0]        snes_pa,
  input  wire logic                   snes_romsel,
  input  wire logic                   snes_rd_n,
  input  wire logic                   snes_wr_n,
  input  wire logic [7:0]             snes_data_in,
  input  wire logic                   cfg_we,
  input  wire logic [3:0]             cfg_addr,
  input  wire logic [7:0]             cfg_data,
  // DUT responses
  input  wire logic [snes_addr_w-1:0] rom_addr,
  input  wire logic [snes_addr_w-1:0] mem_addr,
  input  wire logic [7:0]             mem_wdata,
  input  wire logic                   rom_hit, is_saveram, is_rom, is_writable,
  input  wire logic                   msu_enable, r213f_enable, r2100_hit, snescmd_enable,
  input  wire logic                   nmicmd_enable, return_vector_enable, branch1_enable,
  input  wire logic                   branch2_enable, branch3_enable, gsu_enable,
  input  wire logic                   mem_rd, mem_wr,
  output int                          err_count
);

  int errors = 0;

  // Bus two clocks late, as the decoder sees it
  logic [snes_addr_w-1:0] addr_q1;
  logic [snes_addr_w-1:0] addr_q2;
  logic [pa_w-1:0]        pa_q1;
  logic [pa_w-1:0]        pa_q2;
  logic                   romsel_q1;
  logic                   romsel_q2;
  logic [7:0]             data_q1;
  logic [7:0]             data_q2;
  logic [2:0]             rd_q;       // [1] synced, [2] previous
  logic [2:0]             wr_q;
  // Model copy of the config registers
  logic [feat_w-1:0]      m_feat;
  logic [snes_addr_w-1:0] m_smask;
  logic [snes_addr_w-1:0] m_rmask;
  // Expected decode
  logic [7:0]             bank;
  logic [15:0]            ofs;
  logic                   lo_bank;
  logic [snes_addr_w-1:0] sav_ofs;
  logic [snes_addr_w-1:0] e_addr;
  logic                   e_rom;
  logic                   e_sav;
  logic                   e_hit;
  logic [9:0]             e_en;
  // Expected SRAM request
  logic                   rd_go;
  logic                   wr_go;
  logic                   x_rd;
  logic                   x_wr;
  logic [snes_addr_w-1:0] x_addr;
  logic [7:0]             x_wdata;
  logic [1:0]             warm;       // Pipeline fill after reset

  assign err_count = errors;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    addr_q1   <= snes_addr;
    addr_q2   <= addr_q1;
    pa_q1     <= snes_pa;
    pa_q2     <= pa_q1;
    romsel_q1 <= snes_romsel;
    romsel_q2 <= romsel_q1;
    data_q1   <= snes_data_in;
    data_q2   <= data_q1;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_feat  <= rst_featurebits;
      m_smask <= rst_saveram_mask;
      m_rmask <= rst_rom_mask;
    end else if (cfg_we) begin
      case (cfg_addr)
        cfg_feat_lo:    m_feat[7:0]     <= cfg_data;
        cfg_feat_hi:    m_feat[15:8]    <= cfg_data;
        cfg_sav_mask_0: m_smask[7:0]    <= cfg_data;
        cfg_sav_mask_1: m_smask[15:8]   <= cfg_data;
        cfg_sav_mask_2: m_smask[23:16]  <= cfg_data;
        cfg_rom_mask_0: m_rmask[7:0]    <= cfg_data;
        cfg_rom_mask_1: m_rmask[15:8]   <= cfg_data;
        cfg_rom_mask_2: m_rmask[23:16]  <= cfg_data;
        default: ;  // Upper half of the map is dead
      endcase
    end
  end

  always_comb begin
    bank    = addr_q2[23:16];
    ofs     = addr_q2[15:0];
    lo_bank = !bank[6];  // 00-3F and 80-BF
    e_rom   = (lo_bank && ofs >= 16'h8000) || (!lo_bank && !romsel_q2);
    e_sav   = m_smask[0] && ((bank[6:5] == 2'b11 && !romsel_q2)
              || (lo_bank && ofs >= 16'h6000 && ofs <= 16'h7FFF));
    e_hit   = e_rom || e_sav;
    sav_ofs = lo_bank ? {11'd0, ofs[12:0]} : {7'd0, addr_q2[16:0]};
    if (e_sav) e_addr = sram_base + (sav_ofs & m_smask);
    else if (lo_bank) e_addr = {3'd0, bank[5:0], ofs[14:0]} & m_rmask;  // 32K pages
    else e_addr = {2'd0, addr_q2[21:0]} & m_rmask;                       // Linear 4M
    e_en[0] = m_feat[feat_msu1] && lo_bank && ofs >= 16'h2000 && ofs <= 16'h2007;
    e_en[1] = m_feat[feat_213f] && pa_q2 == 8'h3F;
    e_en[2] = pa_q2 == 8'h00;
    e_en[3] = lo_bank && ofs >= 16'h2A00 && ofs <= 16'h2BFF;
    e_en[4] = addr_q2 == nmicmd_addr;
    e_en[5] = addr_q2 == return_vector_addr;
    e_en[6] = addr_q2 == branch1_addr;
    e_en[7] = addr_q2 == branch2_addr;
    e_en[8] = addr_q2 == branch3_addr;
    e_en[9] = lo_bank && ofs >= 16'h3000 && ofs <= 16'h32FF;  // GSU regs
  end

  // Read at the first synced low, write at the first synced high after low
  assign rd_go = rd_q[2] && !rd_q[1] && e_hit;
  assign wr_go = !wr_q[2] && wr_q[1] && e_sav;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q    <= 3'b111;
      wr_q    <= 3'b111;
      x_rd    <= 1'b0;
      x_wr    <= 1'b0;
      x_addr  <= '0;
      x_wdata <= '0;
      warm    <= '0;
    end else begin
      rd_q <= {rd_q[1:0], snes_rd_n};
      wr_q <= {wr_q[1:0], snes_wr_n};
      x_rd <= rd_go;
      x_wr <= wr_go;
      if (rd_go || wr_go) x_addr <= e_addr;
      if (wr_go) x_wdata <= data_q2;
      if (warm != 2'd3) warm <= warm + 2'd1;
    end
  end

  //////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_val(input string name, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Pre-edge values on both sides
  always @(posedge clk) begin
    if (rst_n && warm[1]) begin
      check_val("rom_addr", rom_addr, e_addr);
      check_bit("is_rom", is_rom, e_rom);
      check_bit("is_saveram", is_saveram, e_sav);
      check_bit("is_writable", is_writable, e_sav);    // Save RAM only
      check_bit("rom_hit", rom_hit, e_hit);
      check_bit("msu_enable", msu_enable, e_en[0]);
      check_bit("r213f_enable", r213f_enable, e_en[1]);
      check_bit("r2100_hit", r2100_hit, e_en[2]);
      check_bit("snescmd_enable", snescmd_enable, e_en[3]);
      check_bit("nmicmd_enable", nmicmd_enable, e_en[4]);
      check_bit("return_vector_enable", return_vector_enable, e_en[5]);
      check_bit("branch1_enable", branch1_enable, e_en[6]);
      check_bit("branch2_enable", branch2_enable, e_en[7]);
      check_bit("branch3_enable", branch3_enable, e_en[8]);
      check_bit("gsu_enable", gsu_enable, e_en[9]);
      check_bit("mem_rd", mem_rd, x_rd);
      check_bit("mem_wr", mem_wr, x_wr);
      if (x_rd || x_wr) check_val("mem_addr", mem_addr, x_addr);
      if (x_wr) check_val("mem_wdata", {16'd0, mem_wdata}, {16'd0, x_wdata});
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_cart.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cart import cart_pkg::*; ();

  localparam int n_reset  = 12;   // Bus holds under reset masks
  localparam int n_decode = 200;
  localparam int n_enable = 120;
  localparam int n_access = 80;   // Per direction
  localparam int n_cfg    = 40;
  // 3 cycles per hold, 9 per strobed access, plus cfg writes and drains
  localparam int test_cycles = 3 * (n_reset + n_decode + n_enable + n_cfg)
                             + 9 * 2 * n_access + 400;
  localparam int watchdog_ns = 2 * 8 * test_cycles;

  logic                   clk;
  logic                   rst_n;
  logic [snes_addr_w-1:0] snes_addr;
  logic [pa_w-1:0]        snes_pa;
  logic                   snes_romsel;
  logic                   snes_rd_n;
  logic                   snes_wr_n;
  logic [7:0]             snes_data_in;
  logic                   cfg_we;
  logic [3:0]             cfg_addr;
  logic [7:0]             cfg_data;
  logic [snes_addr_w-1:0] rom_addr;
  logic [snes_addr_w-1:0] mem_addr;
  logic [7:0]             mem_wdata;
  logic                   rom_hit, is_saveram, is_rom, is_writable;
  logic                   msu_enable, r213f_enable, r2100_hit, snescmd_enable;
  logic                   nmicmd_enable, return_vector_enable, branch1_enable;
  logic                   branch2_enable, branch3_enable, gsu_enable, mem_rd, mem_wr;
  int                     err_count;

  logic [31:0] lcg_state = 32'd52898;
  int          err_mark  = 0;
  int          n_ok      = 0;
  int          n_bad     = 0;

  // Window edges and patch hooks
  logic [snes_addr_w-1:0] edge_addrs [16] = '{
    24'h002000, 24'h002007, 24'h002008, 24'h001FFF, 24'h002A00, 24'h002BFF,
    24'h002C00, nmicmd_addr, return_vector_addr, branch1_addr, branch2_addr,
    branch3_addr, 24'h003000, 24'h0032FF, 24'h003300, 24'h402A00
  };

  cart_top i_cart_top (.*);
  cart_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 125 MHz
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);  // Fold high bits down
  endfunction

  // Bias toward the interesting regions
  function automatic logic [23:0] pick_addr();
    logic [31:0] r;
    r = rand32();
    case (r[31:30])
      2'd0:    pick_addr = r[23:0];
      2'd1:    pick_addr = {r[23], 1'b0, r[21:16], 3'b011, r[12:0]};  // x:6000-7FFF
      2'd2:    pick_addr = {r[23], 2'b11, r[20:0]};                    // 60-7F/E0-FF
      default: pick_addr = {r[23], 1'b0, r[21:16], 1'b1, r[14:0]};    // LoROM half
    endcase
  endfunction

  task automatic cfg_write(input logic [3:0] a, input logic [7:0] d);
    @(posedge clk);
    cfg_we   <= 1'b1;
    cfg_addr <= a;
    cfg_data <= d;
    @(posedge clk);
    cfg_we   <= 1'b0;
  endtask

  task automatic program_masks(input logic force_sav);
    logic [31:0] r;
    r = rand32();
    cfg_write(cfg_sav_mask_0, {r[7:1], r[0] | force_sav});  // Bit 0 is the enable
    cfg_write(cfg_sav_mask_1, r[15:8]);
    cfg_write(cfg_sav_mask_2, r[23:16]);
    r = rand32();
    cfg_write(cfg_rom_mask_0, r[7:0]);
    cfg_write(cfg_rom_mask_1, r[15:8] | 8'hF0);
    cfg_write(cfg_rom_mask_2, r[23:16]);
  endtask

  task automatic hold_bus(input logic [23:0] a, input logic [7:0] pa, input logic romsel);
    @(posedge clk);
    snes_addr   <= a;
    snes_pa     <= pa;
    snes_romsel <= romsel;
    repeat (2) @(posedge clk);  // Steady for 3 cycles
  endtask

  // Strobe low 3 cycles, bus held until the end strobe has passed
  task automatic bus_access(input logic [23:0] a, input logic romsel, input logic wr);
    logic [31:0] r;
    r = rand32();
    @(posedge clk);
    snes_addr    <= a;
    snes_romsel  <= romsel;
    snes_data_in <= r[7:0];
    @(posedge clk);
    if (wr) snes_wr_n <= 1'b0;
    else snes_rd_n <= 1'b0;
    repeat (3) @(posedge clk);
    snes_wr_n <= 1'b1;
    snes_rd_n <= 1'b1;
    repeat (4) @(posedge clk);
  endtask

  task automatic report_test(input string name);
    repeat (6) @(posedge clk);  // Drain the pipeline
    @(negedge clk);             // Checker done with the last edge
    if (err_count == err_mark) begin
      n_ok++;
      $display("[%s] ok", name);
    end else begin
      n_bad++;
      $display("[%s] %0d mismatches", name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    logic [23:0] a;
    logic [7:0]  pa;
    logic [7:0]  feat;
    int          blk;
    rst_n        <= 1'b0;
    snes_addr    <= '0;
    snes_pa      <= '0;
    snes_romsel  <= 1'b1;
    snes_rd_n    <= 1'b1;
    snes_wr_n    <= 1'b1;
    snes_data_in <= '0;
    cfg_we       <= 1'b0;
    cfg_addr     <= '0;
    cfg_data     <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < n_reset; i++) begin  // Mask 0, no save RAM
      r = rand32();
      hold_bus(pick_addr(), r[7:0], r[8]);
    end
    report_test("reset");

    for (int i = 0; i < n_decode; i++) begin
      if (i % 40 == 0) program_masks(1'b0);
      r = rand32();
      hold_bus(pick_addr(), r[7:0], r[8]);
    end
    report_test("decode");

    for (int i = 0; i < n_enable; i++) begin
      r = rand32();
      if (i % 20 == 0) begin
        blk  = i / 20;  // Walks all four MSU/213F gate settings
        feat = r[7:0];
        feat[feat_msu1] = blk[0];
        feat[feat_213f] = blk[1];
        cfg_write(cfg_feat_lo, feat);
        cfg_write(cfg_feat_hi, r[15:8]);
        r = rand32();
      end
      pa = r[10] ? {2'b00, {6{r[9]}}} : r[7:0];  // 00, 3F or anything
      if (i % 2 == 0) a = edge_addrs[(i / 2) % 16];  // Directed every other hold
      else a = pick_addr();
      hold_bus(a, pa, r[8]);
    end
    report_test("enables");

    program_masks(1'b1);
    for (int i = 0; i < n_access; i++) begin
      r = rand32();
      bus_access(pick_addr(), r[0], 1'b0);
    end
    report_test("read");

    program_masks(1'b1);
    for (int i = 0; i < n_access; i++) begin
      r = rand32();
      if (i == n_access / 2) program_masks(1'b0);  // Maybe save RAM off
      bus_access(pick_addr(), r[0], 1'b1);
    end
    report_test("write");

    for (int k = 8; k < 16; k++) begin  // Unmapped config slots
      r = rand32();
      cfg_write(k[3:0], r[7:0]);
    end
    for (int i = 0; i < n_cfg; i++) begin
      r = rand32();
      hold_bus(pick_addr(), r[7:0], r[8]);
    end
    report_test("cfg_map");

    $display("Summary: %0d tests ok, %0d tests with mismatches, %0d mismatches total",
             n_ok, n_bad, err_count);
    if (n_bad == 0 && err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
